/* common/soc_defines.svh */
//************************************************
// Register map of the peripheral bus
// Offsets are byte addresses within a 4 KB slot
// Slaves decode only bits 5:2 of the offset
//************************************************
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Values of address bits 15:12
`define SLOT_SYSCON       4'h0
`define SLOT_GPIO         4'h1

// System controller
`define SYS_VERSION_OFS   6'h00
`define SYS_SWIRQ_OFS     6'h04
`define SYS_MTIME_OFS     6'h08
`define SYS_MTIMECMP_OFS  6'h0c

// GPIO block
`define GPIO_OUT_OFS      6'h00
`define GPIO_OE_OFS       6'h04
`define GPIO_IN_OFS       6'h08
`define GPIO_IRQEN_OFS    6'h0c
`define GPIO_IRQSTAT_OFS  6'h10

`define SYS_VERSION       32'h5256_0102
`define MTIMECMP_RESET    32'hffff_ffff

`endif

/* common/soc_pkg.sv */
//************************************************
// Wishbone classic request and response carriers
// No err, rty, cti or bte lines are carried
//************************************************
`default_nettype none

package soc_pkg;

   typedef logic [15:0] wb_adr_t;
   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  wb_sel_t;
   typedef logic [31:0] gpio_t;

   // 55 bits from master to slave
   typedef struct packed {
      wb_adr_t  adr;
      wb_data_t dat;
      wb_sel_t  sel;
      logic     we;
      logic     cyc;
      logic     stb;
   } wb_req_t;

   // 33 bits from slave to master
   typedef struct packed {
      wb_data_t dat;
      logic     ack;
   } wb_rsp_t;

   typedef struct packed {
      logic timer;
      logic sw3;
      logic sw4;
      logic gpio;
   } irq_t;

   // Byte select widened to a bit mask
   function automatic wb_data_t sel_mask(input wb_sel_t sel);
      wb_data_t mask;
      for (int i = 0; i < 4; i++) begin
         mask[8*i +: 8] = {8{sel[i]}};
      end
      return mask;
   endfunction

endpackage

`default_nettype wire

/* syscon/sys_timer.sv */
//************************************************
// 32-bit machine timer that counts every clock
// mtime wraps silently and cannot be written
//************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module sys_timer import soc_pkg::*; (
   input  logic     i_clk,
   input  logic     i_arst_n,
   input  logic     i_cmp_we,
   input  wb_sel_t  i_cmp_sel,
   input  wb_data_t i_cmp_wdata,
   output wb_data_t o_mtime,
   output wb_data_t o_mtimecmp,
   output logic     o_timer_irq
);

   wb_data_t mtime;
   wb_data_t mtimecmp;
   wb_data_t cmp_mask;

   assign cmp_mask = sel_mask(i_cmp_sel);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime       <= '0;
         mtimecmp    <= `MTIMECMP_RESET;
         o_timer_irq <= 1'b0;
      end else begin
         mtime <= mtime + 32'd1;
         // Byte merge under sel
         if (i_cmp_we) begin
            mtimecmp <= (mtimecmp & ~cmp_mask) | (i_cmp_wdata & cmp_mask);
         end
         o_timer_irq <= (mtime >= mtimecmp);
      end
   end

   assign o_mtime    = mtime;
   assign o_mtimecmp = mtimecmp;

endmodule

`default_nettype wire

/* syscon/sys_regs.sv */
//************************************************
// System controller registers
// Software irq bits take byte 0 of sel only
// Version and mtime are read only
//************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module sys_regs import soc_pkg::*; (
   input  logic    i_clk,
   input  logic    i_arst_n,
   input  wb_req_t i_req,
   output wb_rsp_t o_rsp,
   output logic    o_timer_irq,
   output logic    o_sw_irq3,
   output logic    o_sw_irq4
);

   logic       ack;
   logic       req;
   logic       wr;
   logic [5:0] ofs;
   logic [1:0] sw_irq;
   logic       cmp_we;
   wb_data_t   mtime;
   wb_data_t   mtimecmp;
   wb_data_t   rdat;

   // New request, not yet acked
   assign req    = i_req.cyc & i_req.stb & ~ack;
   assign wr     = req & i_req.we;
   assign ofs    = {i_req.adr[5:2], 2'b00};
   assign cmp_we = wr & (ofs == `SYS_MTIMECMP_OFS);

   sys_timer timer (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_cmp_we    (cmp_we),
      .i_cmp_sel   (i_req.sel),
      .i_cmp_wdata (i_req.dat),
      .o_mtime     (mtime),
      .o_mtimecmp  (mtimecmp),
      .o_timer_irq (o_timer_irq)
   );

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack    <= 1'b0;
         sw_irq <= 2'b00;
      end else begin
         ack <= req;
         if (wr && (ofs == `SYS_SWIRQ_OFS) && i_req.sel[0]) begin
            sw_irq <= i_req.dat[1:0];
         end
      end
   end

   //************************************************
   // Read mux sampled with the ack
   //************************************************
   always_ff @(posedge i_clk) begin
      if (req) begin
         case (ofs)
            `SYS_VERSION_OFS:  rdat <= `SYS_VERSION;
            `SYS_SWIRQ_OFS:    rdat <= {30'd0, sw_irq};
            `SYS_MTIME_OFS:    rdat <= mtime;
            `SYS_MTIMECMP_OFS: rdat <= mtimecmp;
            default:           rdat <= '0;
         endcase
      end
   end

   assign o_rsp     = '{dat: rdat, ack: ack};
   assign o_sw_irq3 = sw_irq[0];
   assign o_sw_irq4 = sw_irq[1];

endmodule

`default_nettype wire

/* gpio/gpio_ctrl.sv */
//************************************************
// 32-bit GPIO with rising edge interrupts
// Pin changes show in the input register after
// three clocks. Narrower pulses may be missed
//************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module gpio_ctrl import soc_pkg::*; (
   input  logic    i_clk,
   input  logic    i_arst_n,
   input  wb_req_t i_req,
   output wb_rsp_t o_rsp,
   input  gpio_t   i_gpio,
   output gpio_t   o_gpio,
   output gpio_t   o_gpio_oe,
   output logic    o_gpio_irq
);

   logic       ack;
   logic       req;
   logic       wr;
   logic [5:0] ofs;
   wb_data_t   wmask;
   wb_data_t   rdat;

   gpio_t      out_q;
   gpio_t      oe_q;
   gpio_t      irqen_q;
   gpio_t      stat_q;
   gpio_t      stat_clr;
   gpio_t      meta_q;
   gpio_t      sync_q;
   gpio_t      prev_q;
   gpio_t      rise;

   assign req   = i_req.cyc & i_req.stb & ~ack;
   assign wr    = req & i_req.we;
   assign ofs   = {i_req.adr[5:2], 2'b00};
   assign wmask = sel_mask(i_req.sel);

   //************************************************
   // Control registers
   //************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack     <= 1'b0;
         out_q   <= '0;
         oe_q    <= '0;
         irqen_q <= '0;
      end else begin
         ack <= req;
         if (wr) begin
            case (ofs)
               `GPIO_OUT_OFS:   out_q   <= (out_q & ~wmask) | (i_req.dat & wmask);
               `GPIO_OE_OFS:    oe_q    <= (oe_q & ~wmask) | (i_req.dat & wmask);
               `GPIO_IRQEN_OFS: irqen_q <= (irqen_q & ~wmask) | (i_req.dat & wmask);
               default:         ;
            endcase
         end
      end
   end

   //************************************************
   // Input sync and edge capture
   //************************************************
   assign rise     = sync_q & ~prev_q & irqen_q;
   assign stat_clr = (wr && (ofs == `GPIO_IRQSTAT_OFS)) ? (i_req.dat & wmask) : '0;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         meta_q <= '0;
         sync_q <= '0;
         prev_q <= '0;
         stat_q <= '0;
      end else begin
         meta_q <= i_gpio;
         sync_q <= meta_q;
         prev_q <= sync_q;
         // A new edge beats a write one to clear
         stat_q <= (stat_q & ~stat_clr) | rise;
      end
   end

   always_ff @(posedge i_clk) begin
      if (req) begin
         case (ofs)
            `GPIO_OUT_OFS:     rdat <= out_q;
            `GPIO_OE_OFS:      rdat <= oe_q;
            `GPIO_IN_OFS:      rdat <= sync_q;
            `GPIO_IRQEN_OFS:   rdat <= irqen_q;
            `GPIO_IRQSTAT_OFS: rdat <= stat_q;
            default:           rdat <= '0;
         endcase
      end
   end

   assign o_rsp      = '{dat: rdat, ack: ack};
   assign o_gpio     = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_gpio_irq = |stat_q;

endmodule

`default_nettype wire

/* logic/wb_decoder.sv */
//************************************************
// Slot decoder on address bits 15:12
// Unmapped slots are acked with zero data, and
// writes to them are dropped
//************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module wb_decoder import soc_pkg::*; (
   input  logic    i_clk,
   input  logic    i_arst_n,
   input  wb_req_t i_wb,
   output wb_rsp_t o_wb,
   output wb_req_t o_sys_req,
   output wb_req_t o_gpio_req,
   input  wb_rsp_t i_sys_rsp,
   input  wb_rsp_t i_gpio_rsp
);

   logic [3:0] slot;
   logic       hit_sys;
   logic       hit_gpio;
   logic       miss_ack;

   assign slot     = i_wb.adr[15:12];
   assign hit_sys  = (slot == `SLOT_SYSCON);
   assign hit_gpio = (slot == `SLOT_GPIO);

   // Only the addressed slave sees stb
   always_comb begin
      o_sys_req      = i_wb;
      o_sys_req.stb  = i_wb.stb & hit_sys;
      o_gpio_req     = i_wb;
      o_gpio_req.stb = i_wb.stb & hit_gpio;
   end

   //************************************************
   // Responder for unmapped slots
   //************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         miss_ack <= 1'b0;
      end else begin
         miss_ack <= i_wb.cyc & i_wb.stb & ~hit_sys & ~hit_gpio & ~miss_ack;
      end
   end

   // Request is held until ack, so the live slot picks the response
   always_comb begin
      case (slot)
         `SLOT_SYSCON: o_wb = i_sys_rsp;
         `SLOT_GPIO:   o_wb = i_gpio_rsp;
         default:      o_wb = '{dat: '0, ack: miss_ack};
      endcase
   end

endmodule

`default_nettype wire

/* logic/wb_periph_top.sv */
//************************************************
// Peripheral side of the SoC behind one Wishbone
// classic port. Every access takes one cycle.
// GPIO pads are split into out, oe and in, so a
// board wrapper has to build the tristate
//************************************************
`timescale 1ns/1ps
`default_nettype none

module wb_periph_top import soc_pkg::*; (
   input  logic    i_clk,
   input  logic    i_arst_n,
   input  wb_req_t i_wb,
   output wb_rsp_t o_wb,
   input  gpio_t   i_gpio,
   output gpio_t   o_gpio,
   output gpio_t   o_gpio_oe,
   output irq_t    o_irq
);

   wb_req_t sys_req;
   wb_req_t gpio_req;
   wb_rsp_t sys_rsp;
   wb_rsp_t gpio_rsp;

   logic    timer_irq;
   logic    sw_irq3;
   logic    sw_irq4;
   logic    gpio_irq;

   wb_decoder decoder (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_wb       (i_wb),
      .o_wb       (o_wb),
      .o_sys_req  (sys_req),
      .o_gpio_req (gpio_req),
      .i_sys_rsp  (sys_rsp),
      .i_gpio_rsp (gpio_rsp)
   );

   sys_regs syscon (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_req       (sys_req),
      .o_rsp       (sys_rsp),
      .o_timer_irq (timer_irq),
      .o_sw_irq3   (sw_irq3),
      .o_sw_irq4   (sw_irq4)
   );

   gpio_ctrl gpio (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_req      (gpio_req),
      .o_rsp      (gpio_rsp),
      .i_gpio     (i_gpio),
      .o_gpio     (o_gpio),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (gpio_irq)
   );

   // Interrupt levels towards the core
   assign o_irq = '{timer: timer_irq,
                    sw3:   sw_irq3,
                    sw4:   sw_irq4,
                    gpio:  gpio_irq};

endmodule

`default_nettype wire

/* dv/tb_assertions.sv */
//************************************************
// Bus and interrupt checks bound to the top level
// Assumes a master that holds its request until ack
// The enable shadow follows bus writes only
//************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module tb_assertions import soc_pkg::*; (
   input logic    i_clk,
   input logic    i_arst_n,
   input wb_req_t i_wb_req,
   input wb_rsp_t i_wb_rsp,
   input gpio_t   i_gpio_out,
   input gpio_t   i_gpio_oe,
   input irq_t    i_irq
);

   int unsigned fail_cnt = 0;
   gpio_t       irqen_seen;
   gpio_t       wr_mask;
   logic        irqen_wr;

   assign wr_mask  = {{8{i_wb_req.sel[3]}}, {8{i_wb_req.sel[2]}},
                      {8{i_wb_req.sel[1]}}, {8{i_wb_req.sel[0]}}};
   assign irqen_wr = i_wb_req.cyc & i_wb_req.stb & i_wb_req.we & ~i_wb_rsp.ack &
                     (i_wb_req.adr[15:12] == `SLOT_GPIO) &
                     ({i_wb_req.adr[5:2], 2'b00} == `GPIO_IRQEN_OFS);

   // Enable register as the bus wrote it
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         irqen_seen <= '0;
      end else if (irqen_wr) begin
         irqen_seen <= (irqen_seen & ~wr_mask) | (i_wb_req.dat & wr_mask);
      end
   end

   //************************************************
   // Handshake
   //************************************************
   ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_wb_rsp.ack |-> (i_wb_req.cyc && i_wb_req.stb))
      else begin
         $error("ack seen outside an open bus cycle");
         fail_cnt = fail_cnt + 1;
      end

   ack_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_wb_rsp.ack |=> !i_wb_rsp.ack)
      else begin
         $error("ack high for two cycles in a row");
         fail_cnt = fail_cnt + 1;
      end

   ack_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_wb_req.cyc && i_wb_req.stb && !i_wb_rsp.ack) |=> i_wb_rsp.ack)
      else begin
         $error("ack did not follow the request by one cycle");
         fail_cnt = fail_cnt + 1;
      end

   //************************************************
   // Interrupts and reset state
   //************************************************
   gpio_irq_gated: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $rose(i_irq.gpio) |-> $past(irqen_seen != '0))
      else begin
         $error("gpio interrupt rose with all enables clear");
         fail_cnt = fail_cnt + 1;
      end

   reset_outputs: assert property (@(posedge i_clk)
      !i_arst_n |-> (!i_wb_rsp.ack && (i_irq == '0) &&
                     (i_gpio_out == '0) && (i_gpio_oe == '0)))
      else begin
         $error("outputs not zero in reset");
         fail_cnt = fail_cnt + 1;
      end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
//************************************************
// Testbench for the peripheral top level
// Bus requests are driven 1 ns after the clock edge
// and responses are sampled on the falling edge
//************************************************
`timescale 1ns/1ps
`default_nettype none
`include "soc_defines.svh"

module tb_top import soc_pkg::*; ();

   // Tests need about 400 cycles
   localparam int TIMEOUT_CYCLES = 3000;

   logic        clk;
   logic        arst_n;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   gpio_t       gpio_in;
   gpio_t       gpio_out;
   gpio_t       gpio_oe;
   irq_t        irq;

   int          errors;
   int          errs_at_start;
   int          checks;
   int          tests;
   int unsigned cycles;
   int unsigned afails;
   logic [31:0] rng_state;

   wb_periph_top dut (
      .i_clk     (clk),
      .i_arst_n  (arst_n),
      .i_wb      (wb_req),
      .o_wb      (wb_rsp),
      .i_gpio    (gpio_in),
      .o_gpio    (gpio_out),
      .o_gpio_oe (gpio_oe),
      .o_irq     (irq)
   );

   bind wb_periph_top tb_assertions u_assert (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_wb_req   (i_wb),
      .i_wb_rsp   (o_wb),
      .i_gpio_out (o_gpio),
      .i_gpio_oe  (o_gpio_oe),
      .i_irq      (o_irq)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
   end

   //************************************************
   // Helpers
   //************************************************
   function automatic wb_adr_t reg_adr(input logic [3:0] slot, input logic [5:0] ofs);
      return {slot, 6'd0, ofs};
   endfunction

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   task automatic bus_access(input wb_adr_t adr, input logic we, input wb_data_t wdat,
                             input wb_sel_t sel, output wb_data_t rdat);
      @(posedge clk);
      #1;
      wb_req = '{adr: adr, dat: wdat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      @(negedge clk);
      while (!wb_rsp.ack) @(negedge clk);
      rdat = wb_rsp.dat;
      @(posedge clk);
      #1;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s expected %h got %h", name, exp, act);
      end
   endtask

   task automatic write_reg(input wb_adr_t adr, input wb_data_t dat, input wb_sel_t sel);
      wb_data_t unused;
      bus_access(adr, 1'b1, dat, sel, unused);
   endtask

   task automatic read_check(input string name, input wb_adr_t adr, input wb_data_t exp);
      wb_data_t got;
      bus_access(adr, 1'b0, '0, 4'hf, got);
      check_val(name, exp, got);
   endtask

   task automatic drive_pins(input gpio_t val);
      @(posedge clk);
      #1;
      gpio_in = val;
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors == errs_at_start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errs_at_start);
      end
      errs_at_start = errors;
   endtask

   //************************************************
   // Tests
   //************************************************
   initial begin
      logic [31:0] pat_out;
      logic [31:0] pat_oe;
      logic [31:0] pat;
      logic [31:0] exp;
      logic [31:0] t1;
      logic [31:0] t2;
      logic [31:0] edge_pat;
      logic [31:0] irq_en;

      arst_n        = 1'b0;
      wb_req        = '0;
      gpio_in       = '0;
      errors        = 0;
      errs_at_start = 0;
      checks        = 0;
      tests         = 0;
      rng_state     = 32'h8e69aea5;
      repeat (10) @(posedge clk);
      #1;
      arst_n = 1'b1;

      read_check("sys version", reg_adr(`SLOT_SYSCON, `SYS_VERSION_OFS), `SYS_VERSION);
      read_check("sys swirq", reg_adr(`SLOT_SYSCON, `SYS_SWIRQ_OFS), 32'd0);
      read_check("sys mtimecmp", reg_adr(`SLOT_SYSCON, `SYS_MTIMECMP_OFS), `MTIMECMP_RESET);
      read_check("gpio out", reg_adr(`SLOT_GPIO, `GPIO_OUT_OFS), 32'd0);
      read_check("gpio oe", reg_adr(`SLOT_GPIO, `GPIO_OE_OFS), 32'd0);
      read_check("gpio in", reg_adr(`SLOT_GPIO, `GPIO_IN_OFS), 32'd0);
      read_check("gpio irqen", reg_adr(`SLOT_GPIO, `GPIO_IRQEN_OFS), 32'd0);
      read_check("gpio irqstat", reg_adr(`SLOT_GPIO, `GPIO_IRQSTAT_OFS), 32'd0);
      @(negedge clk);
      check_val("o_irq", 32'd0, {28'd0, irq});
      finish_test("reset values");

      pat_out = lcg_next();
      pat_oe  = lcg_next();
      write_reg(reg_adr(`SLOT_GPIO, `GPIO_OUT_OFS), pat_out, 4'hf);
      write_reg(reg_adr(`SLOT_GPIO, `GPIO_OE_OFS), pat_oe, 4'hf);
      @(negedge clk);
      check_val("o_gpio", pat_out, gpio_out);
      check_val("o_gpio_oe", pat_oe, gpio_oe);
      read_check("gpio out", reg_adr(`SLOT_GPIO, `GPIO_OUT_OFS), pat_out);
      read_check("gpio oe", reg_adr(`SLOT_GPIO, `GPIO_OE_OFS), pat_oe);
      // Bytes 0 and 2 only
      pat = lcg_next();
      exp = {pat_out[31:24], pat[23:16], pat_out[15:8], pat[7:0]};
      write_reg(reg_adr(`SLOT_GPIO, `GPIO_OUT_OFS), pat, 4'b0101);
      @(negedge clk);
      check_val("o_gpio", exp, gpio_out);
      read_check("gpio out", reg_adr(`SLOT_GPIO, `GPIO_OUT_OFS), exp);
      finish_test("gpio outputs");

      pat = lcg_next();
      drive_pins(pat);
      repeat (3) @(posedge clk);
      read_check("gpio in", reg_adr(`SLOT_GPIO, `GPIO_IN_OFS), pat);
      drive_pins('0);
      repeat (3) @(posedge clk);
      irq_en   = 32'h0000_00ff;
      edge_pat = 32'hf0f0_0f3c;
      write_reg(reg_adr(`SLOT_GPIO, `GPIO_IRQEN_OFS), irq_en, 4'hf);
      drive_pins(edge_pat);
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_val("o_irq.gpio", 32'd1, {31'd0, irq.gpio});
      read_check("gpio irqstat", reg_adr(`SLOT_GPIO, `GPIO_IRQSTAT_OFS), edge_pat & irq_en);
      write_reg(reg_adr(`SLOT_GPIO, `GPIO_IRQSTAT_OFS), edge_pat & irq_en, 4'hf);
      read_check("gpio irqstat", reg_adr(`SLOT_GPIO, `GPIO_IRQSTAT_OFS), 32'd0);
      @(negedge clk);
      check_val("o_irq.gpio", 32'd0, {31'd0, irq.gpio});
      // Rising edges with every enable clear
      write_reg(reg_adr(`SLOT_GPIO, `GPIO_IRQEN_OFS), 32'd0, 4'hf);
      drive_pins('0);
      repeat (3) @(posedge clk);
      drive_pins('1);
      repeat (4) @(posedge clk);
      read_check("gpio irqstat", reg_adr(`SLOT_GPIO, `GPIO_IRQSTAT_OFS), 32'd0);
      @(negedge clk);
      check_val("o_irq.gpio", 32'd0, {31'd0, irq.gpio});
      finish_test("gpio input and interrupts");

      write_reg(reg_adr(`SLOT_SYSCON, `SYS_SWIRQ_OFS), 32'd1, 4'b0001);
      @(negedge clk);
      check_val("o_irq.sw4/sw3", 32'd1, {30'd0, irq.sw4, irq.sw3});
      write_reg(reg_adr(`SLOT_SYSCON, `SYS_SWIRQ_OFS), 32'd2, 4'b0001);
      @(negedge clk);
      check_val("o_irq.sw4/sw3", 32'd2, {30'd0, irq.sw4, irq.sw3});
      // Byte 0 not selected leaves the bits alone
      write_reg(reg_adr(`SLOT_SYSCON, `SYS_SWIRQ_OFS), 32'd3, 4'b1110);
      read_check("sys swirq", reg_adr(`SLOT_SYSCON, `SYS_SWIRQ_OFS), 32'd2);
      write_reg(reg_adr(`SLOT_SYSCON, `SYS_SWIRQ_OFS), 32'd0, 4'hf);
      @(negedge clk);
      check_val("o_irq.sw4/sw3", 32'd0, {30'd0, irq.sw4, irq.sw3});
      finish_test("software interrupts");

      bus_access(reg_adr(`SLOT_SYSCON, `SYS_MTIME_OFS), 1'b0, '0, 4'hf, t1);
      bus_access(reg_adr(`SLOT_SYSCON, `SYS_MTIME_OFS), 1'b0, '0, 4'hf, t2);
      checks++;
      if (!(t2 > t1)) begin
         errors++;
         $display("mtime did not increase between two reads (%h then %h)", t1, t2);
      end
      write_reg(reg_adr(`SLOT_SYSCON, `SYS_MTIMECMP_OFS), 32'd0, 4'hf);
      @(negedge clk);
      check_val("o_irq.timer", 32'd1, {31'd0, irq.timer});
      read_check("sys mtimecmp", reg_adr(`SLOT_SYSCON, `SYS_MTIMECMP_OFS), 32'd0);
      write_reg(reg_adr(`SLOT_SYSCON, `SYS_MTIMECMP_OFS), 32'hffff_ffff, 4'hf);
      @(negedge clk);
      check_val("o_irq.timer", 32'd0, {31'd0, irq.timer});
      finish_test("timer");

      read_check("unmapped read", reg_adr(4'h5, 6'h00), 32'd0);
      write_reg(reg_adr(4'h5, 6'h04), lcg_next(), 4'hf);
      read_check("unmapped read", reg_adr(4'h5, 6'h04), 32'd0);
      finish_test("unmapped slot");

      repeat (2) @(posedge clk);
      afails = dut.u_assert.fail_cnt;
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               tests, checks, errors, afails);
      if (errors == 0 && afails == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+common
common/soc_pkg.sv
syscon/sys_timer.sv
syscon/sys_regs.sv
gpio/gpio_ctrl.sv
logic/wb_decoder.sv
logic/wb_periph_top.sv
dv/tb_assertions.sv
dv/tb_top.sv

/* Makefile */
# Verilator build and run of the peripheral testbench

TOP := tb_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) --Mdir obj_dir -f compile.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
		echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
